// ==== cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl
  import cache_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  cpu_req_t req,
  input  logic     hit,
  input  word_t    rdata,
  input  logic     victim_dirty,
  output logic     access,
  output logic     victim_latch,
  output logic     refill,
  output logic     wb_load,
  output logic     fetch,
  output logic     hit_miss,
  output word_t    q
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  logic        req_valid;

  assign req_valid = req.rden || req.wren;

  always_comb begin
    state_d      = state_q;
    access       = 1'b0;
    victim_latch = 1'b0;
    refill       = 1'b0;
    wb_load      = 1'b0;
    fetch        = 1'b0;
    case (state_q)
      IDLE: begin
        // A request already answered is not looked up again
        if (req_valid && !hit_miss) begin
          access = 1'b1;
          if (!hit)
            state_d = MISS;
        end
      end
      MISS: begin
        victim_latch = 1'b1;
        if (victim_dirty) begin
          wb_load = 1'b1;                               // Victim into write buffer
          state_d = WRITE_BACK;
        end else begin
          state_d = FETCH;
        end
      end
      WRITE_BACK: begin
        state_d = FETCH;                                // mwren out this cycle
      end
      FETCH: begin
        fetch   = 1'b1;
        state_d = FETCH_WAIT;
      end
      FETCH_WAIT: begin
        state_d = REFILL;                               // Memory latency
      end
      REFILL: begin
        refill  = 1'b1;
        state_d = IDLE;
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q  <= IDLE;
      hit_miss <= 1'b0;
    end else begin
      state_q <= state_d;
      if (!req_valid)
        hit_miss <= 1'b0;
      else if (access)
        hit_miss <= hit;                                // Low while the miss is served
    end
  end

  always_ff @(posedge clk) begin
    if (access && hit && req.rden)
      q <= rdata;
  end

  // Retried lookup after a refill hits and answers the CPU
  a_refill_then_hit: assert property (@(posedge clk) disable iff (!reset_n)
    (state_q == REFILL) |=> hit ##1 hit_miss);

endmodule

// ==== cache_mem_model.sv ====
`timescale 1ns/1ps

module cache_mem_model
  import mem_pkg::*;
(
  input  logic     clk,
  input  mem_cmd_t mem_cmd,
  output block_t   mq,
  output int       wr_count
);

  localparam int MEM_BLOCKS = 1024;                     // 8 KB of block memory

  block_t mem [MEM_BLOCKS];

  // Every word starts as a scramble of its full byte address
  function automatic logic [31:0] init_word(mem_addr_t addr);
    return (addr * 32'h9e3779b1) ^ 32'h5bd1e995;
  endfunction

  function automatic int block_index(mem_addr_t addr);
    return int'(addr[12:3]);
  endfunction

  initial begin
    for (int b = 0; b < MEM_BLOCKS; b++) begin
      mem[b] = {init_word(mem_addr_t'(b * 8 + 4)), init_word(mem_addr_t'(b * 8))};
    end
    mq       = '0;
    wr_count = 0;
  end

  // Registered read, mq holds until the next read
  always @(posedge clk) begin
    if (mem_cmd.mrden)
      mq <= mem[block_index(mem_cmd.mrdaddress)];
    if (mem_cmd.mwren) begin
      mem[block_index(mem_cmd.mwraddress)] <= mem_cmd.mdout;
      wr_count <= wr_count + 1;                         // Write log
    end
  end

endmodule

// ==== cache_pkg.sv ====
package cache_pkg;

  localparam int ADDR_W       = 32;
  localparam int WORD_W       = 32;
  localparam int NUM_SETS     = 16;
  localparam int NUM_WAYS     = 4;
  localparam int OFFSET_W     = 3;                      // Byte offset within a block
  localparam int INDEX_W      = $clog2(NUM_SETS);
  localparam int WAY_W        = $clog2(NUM_WAYS);
  localparam int TAG_W        = ADDR_W - INDEX_W - OFFSET_W;
  localparam int AGE_W        = 2;
  localparam int WORD_SEL_BIT = 2;                      // Set means upper word

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [WORD_W-1:0]  word_t;
  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [WAY_W-1:0]   way_t;
  typedef logic [AGE_W-1:0]   age_t;                    // 0 newest, 3 oldest

  localparam age_t AGE_OLDEST = '1;

  // Level request held by the CPU until hit_miss
  typedef struct packed {
    logic  rden;
    logic  wren;
    addr_t addr;
    word_t din;
  } cpu_req_t;

  // Replacement candidate of the indexed set
  typedef struct packed {
    way_t            way;
    logic            dirty;
    addr_t           wb_addr;                           // Block aligned
    mem_pkg::block_t data;
  } victim_t;

  typedef enum logic [2:0] {
    IDLE       = 3'b000,
    MISS       = 3'b001,
    WRITE_BACK = 3'b010,
    FETCH      = 3'b011,
    FETCH_WAIT = 3'b100,
    REFILL     = 3'b101
  } ctrl_state_t;

  function automatic index_t addr_index(addr_t addr);
    return addr[OFFSET_W +: INDEX_W];
  endfunction

  function automatic tag_t addr_tag(addr_t addr);
    return addr[ADDR_W-1 -: TAG_W];
  endfunction

endpackage

// ==== cache_store.sv ====
`timescale 1ns/1ps

module cache_store
  import cache_pkg::*, mem_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  cpu_req_t req,
  input  logic     access,
  input  logic     victim_latch,
  input  logic     refill,
  input  block_t   mq,
  output logic     hit,
  output word_t    rdata,
  output victim_t  victim
);

  // Per set state bits, one column per way
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
  logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
  age_t [NUM_SETS-1:0][NUM_WAYS-1:0] age_q;

  tag_t   tag_mem  [NUM_WAYS][NUM_SETS];
  block_t data_mem [NUM_WAYS][NUM_SETS];

  index_t              idx;
  tag_t                req_tag;
  logic                upper;
  logic [NUM_WAYS-1:0] hit_vec;
  way_t                hit_way;
  block_t              hit_block;
  way_t                vict_way_c;
  way_t                vict_way_q;                      // Way reserved for refill

  function automatic block_t merge_word(block_t blk, word_t word, logic hi);
    block_t res;
    res = blk;
    if (hi)
      res[WORD_W +: WORD_W] = word;
    else
      res[0 +: WORD_W] = word;
    return res;
  endfunction

  assign idx     = addr_index(req.addr);
  assign req_tag = addr_tag(req.addr);
  assign upper   = req.addr[WORD_SEL_BIT];

  // Compare all four tags, lowest matching way wins
  always_comb begin
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = valid_q[idx][w] && (tag_mem[w][idx] == req_tag);
      if (hit_vec[w])
        hit_way = way_t'(w);
    end
  end

  assign hit       = |hit_vec;
  assign hit_block = data_mem[hit_way][idx];
  assign rdata     = upper ? hit_block[WORD_W +: WORD_W] : hit_block[0 +: WORD_W];

  // Empty way first, then the oldest one
  always_comb begin
    logic found;
    found      = 1'b0;
    vict_way_c = way_t'(NUM_WAYS - 1);                  // No way aged out
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && !valid_q[idx][w]) begin
        vict_way_c = way_t'(w);
        found      = 1'b1;
      end
    end
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!found && (age_q[idx][w] == AGE_OLDEST)) begin
        vict_way_c = way_t'(w);
        found      = 1'b1;
      end
    end
  end

  always_comb begin
    victim.way     = vict_way_c;
    victim.dirty   = valid_q[idx][vict_way_c] && dirty_q[idx][vict_way_c];
    victim.wb_addr = {tag_mem[vict_way_c][idx], idx, {OFFSET_W{1'b0}}};
    victim.data    = data_mem[vict_way_c][idx];
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q    <= '0;
      dirty_q    <= '0;
      age_q      <= '0;
      vict_way_q <= '0;
    end else begin
      if (victim_latch)
        vict_way_q <= vict_way_c;
      if (access && hit) begin
        // Age every way at or below the hit way, hit way becomes newest
        for (int w = 0; w < NUM_WAYS; w++) begin
          if (way_t'(w) == hit_way)
            age_q[idx][w] <= '0;
          else if (age_q[idx][w] <= age_q[idx][hit_way])
            age_q[idx][w] <= age_q[idx][w] + 1'b1;
        end
        if (req.wren)
          dirty_q[idx][hit_way] <= 1'b1;
      end
      if (refill) begin
        valid_q[idx][vict_way_q] <= 1'b1;
        dirty_q[idx][vict_way_q] <= req.wren;           // Store miss leaves it dirty
      end
    end
  end

  always_ff @(posedge clk) begin
    if (refill) begin
      data_mem[vict_way_q][idx] <= req.wren ? merge_word(mq, req.din, upper) : mq;
      tag_mem[vict_way_q][idx]  <= req_tag;
    end else if (access && hit && req.wren) begin
      data_mem[hit_way][idx] <= merge_word(hit_block, req.din, upper);
    end
  end

  // Refill comes three cycles after the latch, four with a write-back
  a_refill_after_latch: assert property (@(posedge clk) disable iff (!reset_n)
    refill |-> !victim_latch && ($past(victim_latch, 3) || $past(victim_latch, 4)));

endmodule

// ==== cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb
  import cache_pkg::*, mem_pkg::*;
();

  localparam int SET_COUNT       = 16;
  localparam int WAY_COUNT       = 4;
  localparam int MEM_BLOCKS      = 1024;
  localparam int CLK_HALF        = 4;
  localparam int RESET_CYCLES    = 10;
  localparam int N_DIRECTED      = 14;
  localparam int N_RANDOM        = 200;
  localparam int WATCHDOG_CYCLES = (N_DIRECTED + N_RANDOM) * 10 + 50;

  logic     clk;
  logic     reset_n;
  cpu_req_t cpu_req;
  logic     hit_miss;
  word_t    q;
  mem_cmd_t mem_cmd;
  block_t   mq;
  int       wr_count;

  // Reference copy of the cache and of the memory behind it
  logic        ref_valid [SET_COUNT][WAY_COUNT];
  logic        ref_dirty [SET_COUNT][WAY_COUNT];
  logic [1:0]  ref_age   [SET_COUNT][WAY_COUNT];
  logic [24:0] ref_tag   [SET_COUNT][WAY_COUNT];
  block_t      ref_data  [SET_COUNT][WAY_COUNT];
  block_t      ref_mem   [MEM_BLOCKS];

  // Expected responses and write-backs, oldest first
  logic   resp_rd [$];
  word_t  resp_exp [$];
  addr_t  exp_wb_addr [$];
  block_t exp_wb_data [$];

  string  test_name;
  int     error_count;
  int     check_count;
  int     exp_wb_count;
  int     seed;
  logic   hm_prev;

  cache_top dut_i (
    .clk      (clk),
    .reset_n  (reset_n),
    .cpu_req  (cpu_req),
    .hit_miss (hit_miss),
    .q        (q),
    .mem_cmd  (mem_cmd),
    .mq       (mq)
  );

  cache_mem_model mem_i (
    .clk      (clk),
    .mem_cmd  (mem_cmd),
    .mq       (mq),
    .wr_count (wr_count)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  function automatic logic [31:0] mem_word_at(addr_t addr);
    return (addr * 32'h9e3779b1) ^ 32'h5bd1e995;
  endfunction

  function automatic block_t put_word(block_t blk, word_t word, logic hi);
    block_t res;
    res = blk;
    if (hi)
      res[63:32] = word;
    else
      res[31:0] = word;
    return res;
  endfunction

  function automatic addr_t make_addr(int tag, int set, logic hi);
    return (addr_t'(tag) << 7) | (addr_t'(set) << 3) | (addr_t'(hi) << 2);
  endfunction

  task automatic clear_model();
    for (int s = 0; s < SET_COUNT; s++) begin
      for (int w = 0; w < WAY_COUNT; w++) begin
        ref_valid[s][w] = 1'b0;
        ref_dirty[s][w] = 1'b0;
        ref_age[s][w]   = 2'd0;
      end
    end
    for (int b = 0; b < MEM_BLOCKS; b++)
      ref_mem[b] = {mem_word_at(addr_t'(b * 8 + 4)), mem_word_at(addr_t'(b * 8))};
  endtask

  // Expected read word and write-back of one request, model updated in place
  function automatic word_t ref_access(input addr_t addr, input logic wr, input word_t din,
                                       output logic wb, output addr_t wb_addr,
                                       output block_t wb_data);
    logic [3:0]  s;
    logic [24:0] t;
    logic        hi;
    int          hw;
    logic [1:0]  hage;
    s       = addr[6:3];
    t       = addr[31:7];
    hi      = addr[2];
    wb      = 1'b0;
    wb_addr = '0;
    wb_data = '0;
    hw      = -1;
    for (int w = WAY_COUNT - 1; w >= 0; w--) begin
      if (ref_valid[s][w] && ref_tag[s][w] == t)
        hw = w;
    end
    if (hw < 0) begin
      hw = WAY_COUNT - 1;                               // Nothing aged out
      for (int w = WAY_COUNT - 1; w >= 0; w--) begin
        if (ref_age[s][w] == 2'd3)
          hw = w;
      end
      for (int w = WAY_COUNT - 1; w >= 0; w--) begin
        if (!ref_valid[s][w])
          hw = w;                                       // Empty way wins
      end
      if (ref_valid[s][hw] && ref_dirty[s][hw]) begin
        wb      = 1'b1;
        wb_addr = {ref_tag[s][hw], s, 3'b000};
        wb_data = ref_data[s][hw];
        ref_mem[wb_addr[12:3]] = wb_data;
      end
      ref_data[s][hw]  = ref_mem[addr[12:3]];
      ref_tag[s][hw]   = t;
      ref_valid[s][hw] = 1'b1;
      ref_dirty[s][hw] = 1'b0;
    end
    // Retried lookup after refill behaves as a hit
    hage = ref_age[s][hw];
    for (int w = 0; w < WAY_COUNT; w++) begin
      if (w != hw && ref_age[s][w] <= hage)
        ref_age[s][w] = ref_age[s][w] + 2'd1;
    end
    ref_age[s][hw] = 2'd0;
    if (wr) begin
      ref_data[s][hw]  = put_word(ref_data[s][hw], din, hi);
      ref_dirty[s][hw] = 1'b1;
    end
    return hi ? ref_data[s][hw][63:32] : ref_data[s][hw][31:0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // Called right after a rising edge, returns on one
  task automatic cpu_access(input addr_t addr, input logic wr, input word_t din,
                            output int cycles);
    logic   wb;
    addr_t  wba;
    block_t wbd;
    word_t  exp_word;
    exp_word = ref_access(addr, wr, din, wb, wba, wbd);
    resp_rd.push_back(!wr);
    resp_exp.push_back(exp_word);
    if (wb) begin
      exp_wb_addr.push_back(wba);
      exp_wb_data.push_back(wbd);
      exp_wb_count++;
    end
    cpu_req.rden <= !wr;
    cpu_req.wren <= wr;
    cpu_req.addr <= addr;
    cpu_req.din  <= din;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!hit_miss);
    cpu_req.rden <= 1'b0;
    cpu_req.wren <= 1'b0;
    @(posedge clk);                                     // One idle cycle between requests
  endtask

  // Read data on each new hit_miss, write-backs on each mwren
  always @(posedge clk) begin : compare_proc
    logic  rd;
    word_t exp_word;
    if (hit_miss && !hm_prev) begin
      if (resp_rd.size() == 0) begin
        error_count++;
        $display("The cache answered while no request was outstanding");
      end else begin
        rd       = resp_rd.pop_front();
        exp_word = resp_exp.pop_front();
        if (rd)
          check_value({test_name, " read data"}, exp_word, q);
      end
    end
    if (mem_cmd.mwren) begin
      if (exp_wb_addr.size() == 0) begin
        error_count++;
        $display("The cache wrote a block back that the model did not expect");
      end else begin
        check_value({test_name, " write-back address"}, exp_wb_addr.pop_front(),
                    mem_cmd.mwraddress);
        check_value({test_name, " write-back data"}, exp_wb_data.pop_front(), mem_cmd.mdout);
      end
    end
    hm_prev = hit_miss;
  end

  initial begin : watchdog
    repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles", RESET_CYCLES + WATCHDOG_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : stimulus
    int          cycles;
    logic [31:0] r;
    int          set;
    cpu_req      = '0;
    reset_n      = 1'b0;
    hm_prev      = 1'b0;
    error_count  = 0;
    check_count  = 0;
    exp_wb_count = 0;
    seed         = 32'h5984b6cd;
    test_name    = "reset";
    clear_model();
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);
    check_value("reset hit_miss", 0, hit_miss);
    check_value("reset mrden", 0, mem_cmd.mrden);
    check_value("reset mwren", 0, mem_cmd.mwren);

    test_name = "read miss then hit";
    cpu_access(make_addr(3, 1, 0), 1'b0, '0, cycles);
    cpu_access(make_addr(3, 1, 0), 1'b0, '0, cycles);
    check_value("hit latency", 2, cycles);              // Rises one cycle on, seen an edge later

    test_name = "write miss merge";
    cpu_access(make_addr(6, 4, 1), 1'b1, 32'hcafe0123, cycles);
    cpu_access(make_addr(6, 4, 1), 1'b0, '0, cycles);
    cpu_access(make_addr(6, 4, 0), 1'b0, '0, cycles);

    // Five tags fight over set 7
    test_name = "set 7 eviction";
    cpu_access(make_addr(10, 7, 0), 1'b1, 32'h1000_000a, cycles);
    cpu_access(make_addr(11, 7, 1), 1'b0, '0, cycles);
    cpu_access(make_addr(12, 7, 1), 1'b1, 32'h1000_000c, cycles);
    cpu_access(make_addr(13, 7, 0), 1'b0, '0, cycles);
    cpu_access(make_addr(14, 7, 0), 1'b1, 32'h1000_000e, cycles);
    cpu_access(make_addr(10, 7, 0), 1'b0, '0, cycles);
    cpu_access(make_addr(12, 7, 1), 1'b0, '0, cycles);
    cpu_access(make_addr(13, 7, 1), 1'b0, '0, cycles);
    cpu_access(make_addr(11, 7, 0), 1'b1, 32'h1000_000b, cycles);
    check_value("set 7 write-back count", exp_wb_count, wr_count);

    test_name = "random mix";
    for (int i = 0; i < N_RANDOM; i++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0:    set = 2;
        2'd1:    set = 9;
        default: set = 14;
      endcase
      cpu_access(make_addr(int'(r[4:2]), set, r[5]), r[6], $random(seed), cycles);
    end

    test_name = "end of run";
    check_value("total write-back count", exp_wb_count, wr_count);
    if (resp_rd.size() != 0 || exp_wb_addr.size() != 0) begin
      error_count++;
      $display("Responses or write-backs were still outstanding at the end");
    end
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== cache_top.sv ====
`timescale 1ns/1ps

module cache_top
  import cache_pkg::*, mem_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  cpu_req_t cpu_req,
  output logic     hit_miss,
  output word_t    q,
  output mem_cmd_t mem_cmd,
  input  block_t   mq
);

  logic    access;
  logic    victim_latch;
  logic    refill;
  logic    wb_load;
  logic    fetch;
  logic    hit;
  word_t   rdata;
  victim_t victim;

  cache_ctrl ctrl_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (cpu_req),
    .hit          (hit),
    .rdata        (rdata),
    .victim_dirty (victim.dirty),
    .access       (access),
    .victim_latch (victim_latch),
    .refill       (refill),
    .wb_load      (wb_load),
    .fetch        (fetch),
    .hit_miss     (hit_miss),
    .q            (q)
  );

  cache_store store_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .req          (cpu_req),
    .access       (access),
    .victim_latch (victim_latch),
    .refill       (refill),
    .mq           (mq),
    .hit          (hit),
    .rdata        (rdata),
    .victim       (victim)
  );

  mem_port port_i (
    .clk     (clk),
    .reset_n (reset_n),
    .req     (cpu_req),
    .victim  (victim),
    .wb_load (wb_load),
    .fetch   (fetch),
    .mem_cmd (mem_cmd)
  );

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

  localparam int MEM_ADDR_W = 32;          // Byte address on the memory side
  localparam int BLOCK_W    = 64;          // One block is two CPU words

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [BLOCK_W-1:0]    block_t;

  // Commands from the cache to the block memory
  typedef struct packed {
    logic      mrden;                      // One-cycle read strobe
    mem_addr_t mrdaddress;
    logic      mwren;                      // One-cycle write strobe
    mem_addr_t mwraddress;
    block_t    mdout;
  } mem_cmd_t;

endpackage

// ==== mem_port.sv ====
`timescale 1ns/1ps

module mem_port
  import cache_pkg::*, mem_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  cpu_req_t req,
  input  victim_t  victim,
  input  logic     wb_load,
  input  logic     fetch,
  output mem_cmd_t mem_cmd
);

  logic      mrden_q;
  logic      mwren_q;
  mem_addr_t rd_addr_q;
  mem_addr_t wb_addr_q;                                 // One-entry write buffer
  block_t    wb_data_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mrden_q <= 1'b0;
      mwren_q <= 1'b0;
    end else begin
      mrden_q <= fetch;
      mwren_q <= wb_load;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_load) begin
      wb_addr_q <= victim.wb_addr;
      wb_data_q <= victim.data;
    end
    if (fetch)
      rd_addr_q <= {req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  end

  always_comb begin
    mem_cmd.mrden      = mrden_q;
    mem_cmd.mrdaddress = rd_addr_q;
    mem_cmd.mwren      = mwren_q;
    mem_cmd.mwraddress = wb_addr_q;
    mem_cmd.mdout      = wb_data_q;
  end

  // Write-back drains two cycles before its block fetch
  a_wb_then_fetch: assert property (@(posedge clk) disable iff (!reset_n)
    mem_cmd.mwren |-> !mem_cmd.mrden ##2 mem_cmd.mrden);

endmodule

// ==== src.f ====
mem_pkg.sv
cache_pkg.sv
cache_store.sv
cache_ctrl.sv
mem_port.sv
cache_top.sv
cache_mem_model.sv
cache_tb.sv
